// File: hdl/fpu.sv
// fpu top level
// single precision add, subtract and multiply behind a byte wide
// cs/rd/wr register bus with busy and cmd_end handshake
module fpu (
  input  logic       clk,
  input  logic       arst,
  input  logic [7:0] databus_in,
  output logic [7:0] databus_out,
  input  logic [3:0] addr,
  input  logic       cs,       // active low
  input  logic       rd,       // active low
  input  logic       wr,       // active low
  input  logic       end_ack,  // host has read the result
  output logic       busy,
  output logic       cmd_end
);

  logic op_written;
  logic mul_start;
  logic mul_done;
  logic load_addsub;
  logic load_mul;

  fpu_op_if op_bus ();

  fpu_regs u_regs (
    .clk, .arst, .databus_in, .databus_out, .addr, .cs, .rd, .wr,
    .busy, .load_addsub, .load_mul, .op_written,
    .ops (op_bus.regs)
  );

  fpu_addsub u_addsub (.ops (op_bus.addsub));

  fpu_mul u_mul (
    .clk, .arst, .mul_start, .mul_done,
    .ops (op_bus.mul)
  );

  fpu_ctrl u_ctrl (
    .clk, .arst, .op_written, .mul_done, .end_ack,
    .ops (op_bus.ctrl),
    .busy, .cmd_end, .mul_start, .load_addsub, .load_mul
  );

endmodule

// File: hdl/fpu_addsub.sv
// fpu add/subtract unit, purely combinational
// aligns the smaller operand, adds or subtracts magnitudes by sign,
// then normalizes with truncation
module fpu_addsub (
  fpu_op_if.addsub ops
);
  import fpu_pkg::*;

  logic             sign_a;
  logic             sign_b;      // after sub inversion
  logic [man_w-1:0] man_a;
  logic [man_w-1:0] man_b;
  logic [7:0]       exp_big;     // result exponent before normalize
  logic [7:0]       exp_diff;
  logic [man_w-1:0] man_big;
  logic [man_w-1:0] man_small;   // already shifted right
  logic             sign_big;
  logic             sign_small;
  logic [man_w:0]   mag;         // magnitude plus carry bit
  logic             res_sign;
  logic [4:0]       lz;          // leading zeros of mag[23:0]
  logic [man_w-1:0] norm_man;
  logic [7:0]       res_exp;
  fpu_word_u        res;

  always_comb begin
    sign_a = ops.a.ieee.sign;
    sign_b = ops.b.ieee.sign ^ (ops.operation == op_sub); // a - b = a + (-b)
    man_a  = (ops.a.ieee.exp == 8'd0) ? '0 : {1'b1, ops.a.ieee.frac};
    man_b  = (ops.b.ieee.exp == 8'd0) ? '0 : {1'b1, ops.b.ieee.frac};

    // smaller exponent side gets shifted, dropped bits are lost
    if (ops.a.ieee.exp >= ops.b.ieee.exp) begin
      exp_big    = ops.a.ieee.exp;
      exp_diff   = ops.a.ieee.exp - ops.b.ieee.exp;
      man_big    = man_a;
      man_small  = man_b >> exp_diff;
      sign_big   = sign_a;
      sign_small = sign_b;
    end else begin
      exp_big    = ops.b.ieee.exp;
      exp_diff   = ops.b.ieee.exp - ops.a.ieee.exp;
      man_big    = man_b;
      man_small  = man_a >> exp_diff;
      sign_big   = sign_b;
      sign_small = sign_a;
    end

    // same signs add, else larger magnitude minus smaller
    if (sign_big == sign_small) begin
      mag      = {1'b0, man_big} + {1'b0, man_small};
      res_sign = sign_big;
    end else if (man_big >= man_small) begin
      mag      = {1'b0, man_big - man_small};
      res_sign = sign_big;
    end else begin
      mag      = {1'b0, man_small - man_big}; // equal exps, b larger
      res_sign = sign_small;
    end

    lz = '0;
    for (int i = 0; i < man_w; i++) begin
      if (mag[i]) lz = 5'(man_w - 1 - i); // highest set bit wins
    end

    if (mag[man_w]) begin
      norm_man = mag[man_w:1]; // carry out, one right shift
      res_exp  = exp_big + 8'd1;
    end else begin
      norm_man = mag[man_w-1:0] << lz;
      res_exp  = exp_big - 8'(lz);
    end

    res.ieee.sign = res_sign;
    res.ieee.exp  = res_exp;
    res.ieee.frac = norm_man[man_w-2:0];
    if (mag == '0) res = '0; // exact cancel or both zero

    ops.addsub_res = res;
  end

endmodule

// File: hdl/fpu_ctrl.sv
// fpu sequencer
// starts the unit picked by the opcode, strobes the result load,
// then holds cmd_end until the host acknowledges
module fpu_ctrl (
  input  logic   clk,
  input  logic   arst,
  input  logic   op_written,
  input  logic   mul_done,
  input  logic   end_ack,
  fpu_op_if.ctrl ops,
  output logic   busy,
  output logic   cmd_end,
  output logic   mul_start,
  output logic   load_addsub,
  output logic   load_mul
);
  import fpu_pkg::*;

  fpu_state_e state;
  fpu_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      idle_st:
        if (op_written) begin
          case (ops.operation)
            op_add, op_sub: state_nxt = addsub_st;
            op_mul:         state_nxt = mul_start_st;
            default:        state_nxt = idle_st;
          endcase
        end
      addsub_st:       state_nxt = result_valid_st; // operands settled
      mul_start_st:    state_nxt = mul_run_st;
      mul_run_st:      if (mul_done) state_nxt = result_valid_st;
      result_valid_st: if (end_ack) state_nxt = idle_st;
      default:         state_nxt = idle_st;
    endcase
  end

  assign mul_start   = (state == mul_start_st);
  assign load_addsub = (state == addsub_st);
  assign load_mul    = (state == mul_run_st) && mul_done;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state   <= idle_st;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      state   <= state_nxt;
      busy    <= (state_nxt != idle_st);        // also high while result waits
      cmd_end <= (state_nxt == result_valid_st);
    end
  end

endmodule

// File: hdl/fpu_mul.sv
// fpu multiplier
// shift-and-add over the 24 bit mantissas, two cycles per step,
// then one cycle to normalize and register the result
module fpu_mul (
  input  logic  clk,
  input  logic  arst,
  input  logic  mul_start,  // one cycle, loads mantissas
  output logic  mul_done,   // one cycle, mul_res valid
  fpu_op_if.mul ops
);
  import fpu_pkg::*;

  logic [man_w-1:0] mcand;      // multiplicand, mantissa of a
  logic [2*man_w:0] prod;       // product high half + carry | multiplier
  logic [4:0]       step_cnt;
  logic             running;
  logic             add_ph;     // 1 = add phase, 0 = shift phase
  logic             norm_pend;
  logic [man_w-1:0] top;        // top 24 bits of the 48 bit product
  logic [9:0]       exp_sum;
  fpu_word_u        res_n;
  fpu_word_u        res_r;

  assign top         = prod[2*man_w-1:man_w];
  assign ops.mul_res = res_r;

  // normalize, exponent a + b - bias, plus one on top bit set
  always_comb begin
    exp_sum = {2'b0, ops.a.ieee.exp} + {2'b0, ops.b.ieee.exp} - 10'(exp_bias)
            + {9'b0, top[man_w-1]};
    res_n.ieee.sign = ops.a.ieee.sign ^ ops.b.ieee.sign;
    res_n.ieee.exp  = exp_sum[7:0];
    res_n.ieee.frac = top[man_w-1] ? top[man_w-2:0] : {top[man_w-3:0], 1'b0};
    if (ops.a.ieee.exp == 8'd0 || ops.b.ieee.exp == 8'd0) res_n = '0;
  end

  // step sequencing
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      running   <= 1'b0;
      add_ph    <= 1'b0;
      step_cnt  <= '0;
      norm_pend <= 1'b0;
      mul_done  <= 1'b0;
    end else begin
      mul_done <= 1'b0;
      if (mul_start) begin
        running   <= 1'b1;
        add_ph    <= 1'b1;
        step_cnt  <= '0;
        norm_pend <= 1'b0;
      end else if (running) begin
        add_ph <= !add_ph;
        if (add_ph) step_cnt <= step_cnt + 5'd1; // counted on the add
        else if (step_cnt == 5'(mul_steps)) begin
          running   <= 1'b0; // last shift done
          norm_pend <= 1'b1;
        end
      end else if (norm_pend) begin
        norm_pend <= 1'b0;
        mul_done  <= 1'b1;
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (mul_start) begin
      mcand <= {ops.a.ieee.exp != 8'd0, ops.a.ieee.frac};
      prod  <= {{(man_w+1){1'b0}}, ops.b.ieee.exp != 8'd0, ops.b.ieee.frac};
    end else if (running) begin
      if (add_ph) begin
        if (prod[0]) prod[2*man_w:man_w] <= prod[2*man_w:man_w] + {1'b0, mcand};
      end else begin
        prod <= prod >> 1; // next multiplier bit into prod[0]
      end
    end else if (norm_pend) begin
      res_r <= res_n; // held until the next start
    end
  end

endmodule

// File: hdl/fpu_op_if.sv
// operand bus inside the fpu
// carries a, b and the opcode out of the register file
// and the two unit results back into it
interface fpu_op_if;
  import fpu_pkg::*;

  fpu_word_u a;          // operand a
  fpu_word_u b;          // operand b
  fpu_op_e   operation;  // last accepted opcode
  fpu_word_u addsub_res; // add/sub unit, combinational
  fpu_word_u mul_res;    // multiplier, registered

  modport regs   (output a, b, operation, input addsub_res, mul_res);
  modport addsub (input a, b, operation, output addsub_res);
  modport mul    (input a, b, output mul_res);
  modport ctrl   (input operation);

endinterface

// File: hdl/fpu_pkg.sv
// fpu shared definitions
// single-precision format constants, host register map, opcodes,
// controller states and the dual-view operand word
package fpu_pkg;

  // format
  localparam int exp_bias  = 127; // ieee single bias
  localparam int man_w     = 24;  // mantissa incl hidden one
  localparam int mul_steps = 24;  // one step per multiplier bit

  // host register map, byte addresses
  localparam logic [3:0] addr_a0   = 4'd0; // a bytes 0..3
  localparam logic [3:0] addr_b0   = 4'd4; // b bytes 4..7
  localparam logic [3:0] addr_op   = 4'd8; // opcode, write starts op
  localparam logic [3:0] addr_res0 = 4'd9; // result bytes 9..12

  // opcodes, 3 and up are not run
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_mul = 4'd2
  } fpu_op_e;

  // one 32 bit word, seen as fields by the datapath
  // and as bytes by the host bus
  typedef union packed {
    struct packed {
      logic        sign;
      logic [7:0]  exp;  // biased, zero means value zero
      logic [22:0] frac; // hidden one not stored
    } ieee;
    logic [3:0][7:0] bytes; // bytes[0] is the low byte
  } fpu_word_u;

  // sequencer states
  typedef enum logic [2:0] {
    idle_st,         // waiting for an opcode write
    addsub_st,       // combinational add/sub settles here
    mul_start_st,    // one cycle start pulse to multiplier
    mul_run_st,      // waiting for mul_done
    result_valid_st  // cmd_end up until end_ack
  } fpu_state_e;

endpackage

// File: hdl/fpu_regs.sv
// fpu host register file
// byte writes into a and b, opcode register with start flag,
// result register and the byte read mux
module fpu_regs (
  input  logic       clk,
  input  logic       arst,
  input  logic [7:0] databus_in,
  output logic [7:0] databus_out,
  input  logic [3:0] addr,
  input  logic       cs,           // active low
  input  logic       rd,           // active low
  input  logic       wr,           // active low
  input  logic       busy,
  input  logic       load_addsub,
  input  logic       load_mul,
  output logic       op_written,   // opcode accepted, waiting for ctrl
  fpu_op_if.regs     ops
);
  import fpu_pkg::*;

  fpu_word_u  a_r;
  fpu_word_u  b_r;
  fpu_word_u  res_r;
  fpu_op_e    op_r;
  logic       wr_en;
  logic       kept_op;
  logic [3:0] a_off;  // addr relative to each block base
  logic [3:0] b_off;
  logic [3:0] r_off;

  assign wr_en   = !cs && !wr && !busy; // no writes while an op runs
  assign kept_op = databus_in[3:0] inside {op_add, op_sub, op_mul};
  assign a_off   = addr - addr_a0;
  assign b_off   = addr - addr_b0;
  assign r_off   = addr - addr_res0;

  assign ops.a         = a_r;
  assign ops.b         = b_r;
  assign ops.operation = op_r;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      a_r        <= '0;
      b_r        <= '0;
      op_r       <= op_add;
      res_r      <= '0;
      op_written <= 1'b0;
    end else begin
      if (busy) op_written <= 1'b0; // ctrl has taken it
      if (wr_en) begin
        if (a_off < 4'd4) a_r.bytes[a_off[1:0]] <= databus_in;
        else if (b_off < 4'd4) b_r.bytes[b_off[1:0]] <= databus_in;
        else if (addr == addr_op && kept_op) begin
          op_r       <= fpu_op_e'(databus_in[3:0]);
          op_written <= 1'b1;
        end
      end
      // strobes come from ctrl, never both at once
      if (load_addsub) res_r <= ops.addsub_res;
      else if (load_mul) res_r <= ops.mul_res;
    end
  end

  // read mux, zero when not selected
  always_comb begin
    databus_out = '0;
    if (!cs && !rd) begin
      if (a_off < 4'd4) databus_out = a_r.bytes[a_off[1:0]];
      else if (b_off < 4'd4) databus_out = b_r.bytes[b_off[1:0]];
      else if (addr == addr_op) databus_out = {4'b0, op_r};
      else if (r_off < 4'd4) databus_out = res_r.bytes[r_off[1:0]];
    end
  end

endmodule

// File: sim.f
hdl/fpu_pkg.sv
hdl/fpu_op_if.sv
hdl/fpu_regs.sv
hdl/fpu_addsub.sv
hdl/fpu_mul.sv
hdl/fpu_ctrl.sv
hdl/fpu.sv
tb/tb_fpu.sv

// File: tb/tb_fpu.sv
// fpu testbench
// drives the byte bus, runs add, sub and mul against a float model,
// checks the busy/cmd_end handshake and an unsupported opcode
module tb_fpu;
  timeunit 1ns;
  timeprecision 100ps;
  import fpu_pkg::*;

  localparam int n_add      = 20;
  localparam int n_sub      = 15;
  localparam int n_mul      = 20;
  localparam int max_cycles = 6000; // ~60 ops of up to ~60 cycles plus margin
  localparam int end_wait   = 200;  // per op limit for cmd_end

  logic clk, arst, cs, rd, wr, end_ack;
  logic [7:0] databus_in, databus_out;
  logic [3:0] addr;
  logic busy, cmd_end;
  integer seed = 32'h4cf7;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  string name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  fpu dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // expected word from float arithmetic with truncation
  function automatic logic [31:0] ref_fpu(input logic [31:0] a, b, input logic [3:0] op);
    logic sa, sb, rs;
    int ea, eb, er;
    longint ma, mb, sum, p;
    sa = a[31];
    sb = b[31] ^ (op == 4'd1); // sub flips b
    ea = a[30:23];
    eb = b[30:23];
    ma = (ea == 0) ? 0 : {1'b1, a[22:0]};
    mb = (eb == 0) ? 0 : {1'b1, b[22:0]};
    if (op == 4'd2) begin
      if (ea == 0 || eb == 0) return 32'h0;
      p  = (ma * mb) >> 24; // top 24 of the 48 bit product
      er = ea + eb - 127;
      if (p >= (64'sd1 << 23)) er++;
      else p = p << 1;
      return {a[31] ^ b[31], er[7:0], p[22:0]};
    end
    if (ea >= eb) begin
      er = ea;
      mb = mb >> (ea - eb);
    end else begin
      er = eb;
      ma = ma >> (eb - ea);
    end
    sum = (sa ? -ma : ma) + (sb ? -mb : mb); // signed magnitudes
    if (sum == 0) return 32'h0;
    rs = (sum < 0);
    if (rs) sum = -sum;
    if (sum >= (64'sd1 << 24)) begin
      sum = sum >> 1;
      er++;
    end
    while (sum < (64'sd1 << 23)) begin
      sum = sum << 1;
      er--;
    end
    return {rs, er[7:0], sum[22:0]};
  endfunction

  // exponent 64..190 keeps every result in range
  function automatic logic [31:0] rand_float();
    logic [31:0] r1, r2;
    r1 = $random(seed);
    r2 = $random(seed);
    return {r1[31], 8'd64 + 8'(r1[15:0] % 127), r2[22:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expv, actv);
    name_q.push_back(name);
    exp_q.push_back(expv);
    act_q.push_back(actv);
  endtask

  task automatic write_byte(input logic [3:0] a, input logic [7:0] d);
    @(posedge clk);
    cs         <= 1'b0;
    wr         <= 1'b0;
    addr       <= a;
    databus_in <= d;
    @(posedge clk); // write lands on this edge
    cs <= 1'b1;
    wr <= 1'b1;
  endtask

  task automatic read_byte(input logic [3:0] a, output logic [7:0] d);
    @(posedge clk);
    cs   <= 1'b0;
    rd   <= 1'b0;
    addr <= a;
    @(negedge clk);
    d = databus_out; // comb read has settled by mid cycle
    @(posedge clk);
    cs <= 1'b1;
    rd <= 1'b1;
  endtask

  task automatic write_word(input logic [3:0] base, input logic [31:0] w);
    for (int i = 0; i < 4; i++) write_byte(base + 4'(i), w[8*i +: 8]);
  endtask

  task automatic read_word(input logic [3:0] base, output logic [31:0] w);
    logic [7:0] d;
    for (int i = 0; i < 4; i++) begin
      read_byte(base + 4'(i), d);
      w[8*i +: 8] = d;
    end
  endtask

  task automatic wait_cmd_end(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_end && n < end_wait) begin
      @(negedge clk);
      n++;
    end
    assert (cmd_end) else begin
      errors++;
      $display("%s: cmd_end did not rise within %0d cycles", name, end_wait);
    end
  endtask

  task automatic send_ack();
    @(posedge clk);
    end_ack <= 1'b1;
    @(posedge clk); // dut goes idle here
    end_ack <= 1'b0;
    @(negedge clk);
  endtask

  task automatic run_op(input string name, input logic [31:0] a, b, input logic [3:0] op);
    logic [31:0] r;
    write_word(addr_a0, a);
    write_word(addr_b0, b);
    write_byte(addr_op, {4'b0, op});
    wait_cmd_end(name);
    read_word(addr_res0, r);
    check_value(name, ref_fpu(a, b, op), r);
    send_ack();
  endtask

  // compares queued results in order
  initial begin
    string nm;
    logic [31:0] e, v;
    forever begin
      @(posedge clk);
      while (act_q.size() > 0) begin
        nm = name_q.pop_front();
        e  = exp_q.pop_front();
        v  = act_q.pop_front();
        checks++;
        assert (v === e) else begin
          errors++;
          $display("[FAIL] %s expected %h actual %h", nm, e, v);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout, run did not finish within %0d cycles", max_cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    logic [31:0] a, b, r1, r2;
    logic [7:0] d;
    arst       = 1'b1;
    cs         = 1'b1;
    rd         = 1'b1;
    wr         = 1'b1;
    end_ack    = 1'b0;
    addr       = '0;
    databus_in = '0;
    repeat (2) @(posedge clk);
    arst <= 1'b0;

    // reset values and readback
    @(negedge clk);
    check_value("reset_flags", 32'h0, {busy, cmd_end});
    for (int i = 0; i < 13; i++) begin
      read_byte(4'(i), d);
      check_value($sformatf("reset_byte_%0d", i), 32'h0, d);
    end
    a = rand_float();
    b = rand_float();
    write_word(addr_a0, a);
    write_word(addr_b0, b);
    read_word(addr_a0, r1);
    check_value("readback_a", a, r1);
    read_word(addr_b0, r1);
    check_value("readback_b", b, r1);
    write_byte(addr_op, 8'd1);
    read_byte(addr_op, d); // reads still work while busy
    check_value("readback_op", 32'd1, d);
    wait_cmd_end("readback_sub");
    send_ack();

    // addition
    run_op("add_equal_exp", 32'h3fc00000, 32'h3fa00000, 4'd0); // 1.5 + 1.25
    run_op("add_diff_exp", 32'h40400000, 32'h3e800000, 4'd0);  // 3 + 0.25
    for (int i = 0; i < n_add; i++) begin
      run_op($sformatf("add_%0d", i), rand_float(), rand_float(), 4'd0);
    end

    // subtraction
    a = rand_float();
    run_op("sub_self", a, a, 4'd1);
    for (int i = 0; i < n_sub; i++) begin
      run_op($sformatf("sub_%0d", i), rand_float(), rand_float(), 4'd1);
    end

    // multiplication without and with carry into the top bit
    run_op("mul_no_carry", 32'h3f800000, 32'h3f800000, 4'd2);
    run_op("mul_carry", 32'h3fffffff, 32'h3fffffff, 4'd2);
    for (int i = 0; i < n_mul; i++) begin
      run_op($sformatf("mul_%0d", i), rand_float(), rand_float(), 4'd2);
    end

    // handshake
    a = rand_float();
    b = rand_float();
    write_word(addr_a0, a);
    write_word(addr_b0, b);
    write_byte(addr_op, 8'd0);
    @(posedge clk);
    @(negedge clk);
    check_value("hs_busy_rise", 32'h1, busy);
    wait_cmd_end("hs_add");
    read_word(addr_res0, r1);
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_value("hs_hold_flags", 32'h3, {busy, cmd_end});
    write_byte(addr_a0, ~a[7:0]); // must be ignored
    read_byte(addr_a0, d);
    check_value("hs_blocked_write", a[7:0], d);
    read_word(addr_res0, r2);
    check_value("hs_result_stable", r1, r2);
    check_value("hs_result", ref_fpu(a, b, 4'd0), r1);
    send_ack();
    check_value("hs_after_ack", 32'h0, {busy, cmd_end});

    // opcode 3 is dropped
    write_byte(addr_op, 8'd3);
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_value("bad_op_idle", 32'h0, {busy, cmd_end});
    end
    read_byte(addr_op, d); // still the add from the handshake
    check_value("bad_op_reg", 32'h0, d);
    run_op("add_after_bad_op", rand_float(), rand_float(), 4'd0);

    repeat (3) @(posedge clk); // let the checker drain
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
